//--- cpu.f
cpu_pkg.sv
mem_bus_if.sv
register_bank.sv
fetch.sv
decode.sv
execute.sv
mem_arbiter.sv
unified_ram.sv
cpu.sv
tb_cpu.sv

//--- cpu.sv
module cpu (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          load_en,
    input  logic [cpu_pkg::addr_bits-1:0] load_addr,
    input  logic [cpu_pkg::xlen-1:0]      load_data,
    output logic                          load_busy,
    output logic                          halted,
    output logic                          retire_valid,
    output logic [cpu_pkg::xlen-1:0]      retire_pc,
    output logic [4:0]                    retire_rd,
    output logic [cpu_pkg::xlen-1:0]      retire_value
);

    mem_bus_if if_bus ();
    mem_bus_if dm_bus ();
    mem_bus_if ld_bus ();

    logic                          instr_valid;
    logic [31:0]                   instr;
    logic [cpu_pkg::xlen-1:0]      instr_pc;
    logic                          done;
    logic                          branch_taken;
    logic [cpu_pkg::xlen-1:0]      branch_target;
    logic                          halt;
    logic [4:0]                    raddr1;
    logic [4:0]                    raddr2;
    logic [cpu_pkg::xlen-1:0]      rdata1;
    logic [cpu_pkg::xlen-1:0]      rdata2;
    cpu_pkg::decoded_t             dec;
    logic                          rf_we;
    logic [4:0]                    rf_waddr;
    logic [cpu_pkg::xlen-1:0]      rf_wdata;
    logic                          ram_en;
    logic                          ram_we;
    logic [cpu_pkg::addr_bits-1:0] ram_addr;
    logic [cpu_pkg::xlen-1:0]      ram_wdata;
    logic [cpu_pkg::xlen-1:0]      ram_rdata;

    // The program-load port is a write-only master
    assign ld_bus.req = load_en;
    assign ld_bus.we = 1'b1;
    assign ld_bus.addr = load_addr;
    assign ld_bus.wdata = load_data;
    assign load_busy = !ld_bus.gnt;

    fetch u_fetch (
        .clk(clk),
        .rst(rst),
        .start(start),
        .halted(halted),
        .bus(if_bus),
        .instr_valid(instr_valid),
        .instr(instr),
        .instr_pc(instr_pc),
        .done(done),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .halt(halt)
    );

    decode u_decode (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .instr_pc(instr_pc),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .dec(dec)
    );

    register_bank u_register_bank (
        .clk(clk),
        .rst(rst),
        .we(rf_we),
        .waddr(rf_waddr),
        .wdata(rf_wdata),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    execute u_execute (
        .clk(clk),
        .rst(rst),
        .dec(dec),
        .bus(dm_bus),
        .rf_we(rf_we),
        .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata),
        .done(done),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .halt(halt),
        .retire_pc(retire_pc)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk),
        .rst(rst),
        .ld(ld_bus),
        .dm(dm_bus),
        .im(if_bus),
        .ram_en(ram_en),
        .ram_we(ram_we),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    unified_ram u_unified_ram (
        .clk(clk),
        .en(ram_en),
        .we(ram_we),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    assign retire_valid = done;
    assign retire_rd = rf_waddr;
    assign retire_value = rf_wdata;

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;
    localparam int mem_words = 1024;
    localparam int addr_bits = 10;

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] fetch_idle = 3'd0;
    localparam logic [2:0] fetch_request = 3'd1;
    localparam logic [2:0] fetch_wait_data = 3'd2;
    localparam logic [2:0] fetch_wait_done = 3'd3;
    localparam logic [2:0] fetch_halted = 3'd4;

    localparam logic [1:0] ex_idle = 2'd0;
    localparam logic [1:0] ex_mem_req = 2'd1;
    localparam logic [1:0] ex_mem_data = 2'd2;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;  // Zero for anything that writes no register
        alu_op_t         alu_op;
        logic            use_imm;
        logic [xlen-1:0] imm;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            branch_ne;
        logic            is_halt;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
    } decoded_t;

endpackage

//--- decode.sv
module decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [cpu_pkg::xlen-1:0] instr_pc,
    output logic [4:0]               raddr1,
    output logic [4:0]               raddr2,
    input  logic [cpu_pkg::xlen-1:0] rdata1,
    input  logic [cpu_pkg::xlen-1:0] rdata2,
    output cpu_pkg::decoded_t        dec
);

    cpu_pkg::instr_u   iw;
    cpu_pkg::decoded_t nxt;
    logic [6:0]        opcode;
    logic [2:0]        funct3;

    assign iw = instr;
    assign opcode = iw.r_fmt.opcode;
    assign funct3 = iw.r_fmt.funct3;
    assign raddr1 = iw.r_fmt.rs1;
    assign raddr2 = iw.r_fmt.rs2;

    always_comb begin
        nxt = '0;
        nxt.valid = instr_valid;
        nxt.pc = instr_pc;
        nxt.alu_op = cpu_pkg::alu_add;
        nxt.rs1_value = rdata1;
        nxt.rs2_value = rdata2;
        case (opcode)
            cpu_pkg::op_reg, cpu_pkg::op_imm: begin
                nxt.rd = iw.r_fmt.rd;
                nxt.use_imm = (opcode == cpu_pkg::op_imm);
                nxt.imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
                case (funct3)
                    3'b000: begin
                        if (!nxt.use_imm && iw.r_fmt.funct7[5]) begin
                            nxt.alu_op = cpu_pkg::alu_sub;
                        end
                    end
                    3'b100: nxt.alu_op = cpu_pkg::alu_xor;
                    3'b110: nxt.alu_op = cpu_pkg::alu_or;
                    3'b111: nxt.alu_op = cpu_pkg::alu_and;
                    default: nxt.rd = 5'd0;  // Shifts and compares retire as NOP
                endcase
            end
            cpu_pkg::op_load: begin
                nxt.rd = iw.i_fmt.rd;
                nxt.imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
                nxt.is_load = 1'b1;
            end
            cpu_pkg::op_store: begin
                nxt.imm = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
                nxt.is_store = 1'b1;
            end
            cpu_pkg::op_branch: begin
                nxt.imm = {{20{iw.b_fmt.imm_12}}, iw.b_fmt.imm_11, iw.b_fmt.imm_10_5,
                           iw.b_fmt.imm_4_1, 1'b0};
                nxt.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                nxt.branch_ne = funct3[0];
            end
            cpu_pkg::op_lui: begin
                nxt.rd = iw.u_fmt.rd;
                nxt.use_imm = 1'b1;
                nxt.imm = {iw.u_fmt.imm, 12'd0};
                nxt.alu_op = cpu_pkg::alu_pass_b;
            end
            cpu_pkg::op_system: nxt.is_halt = (funct3 == 3'b000) && (iw.i_fmt.imm == 12'd0);
            default: ;
        endcase
    end

    // Holding register between decode and execute
    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec <= nxt;
        end
    end

endmodule

//--- execute.sv
module execute (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_pkg::decoded_t        dec,
    mem_bus_if.master                bus,
    output logic                     rf_we,
    output logic [4:0]               rf_waddr,
    output logic [cpu_pkg::xlen-1:0] rf_wdata,
    output logic                     done,
    output logic                     branch_taken,
    output logic [cpu_pkg::xlen-1:0] branch_target,
    output logic                     halt,
    output logic [cpu_pkg::xlen-1:0] retire_pc
);

    logic [1:0]               state;
    cpu_pkg::decoded_t        held;
    cpu_pkg::decoded_t        cur;
    logic                     mem_op;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic [cpu_pkg::xlen-1:0] mem_addr;

    // A load or store keeps its decoded item here until the access ends
    assign cur = (state == cpu_pkg::ex_idle) ? dec : held;
    assign mem_op = dec.is_load || dec.is_store;

    assign op_b = cur.use_imm ? cur.imm : cur.rs2_value;

    always_comb begin
        case (cur.alu_op)
            cpu_pkg::alu_sub: alu_result = cur.rs1_value - op_b;
            cpu_pkg::alu_and: alu_result = cur.rs1_value & op_b;
            cpu_pkg::alu_or: alu_result = cur.rs1_value | op_b;
            cpu_pkg::alu_xor: alu_result = cur.rs1_value ^ op_b;
            cpu_pkg::alu_pass_b: alu_result = op_b;
            default: alu_result = cur.rs1_value + op_b;
        endcase
    end

    assign mem_addr = cur.rs1_value + cur.imm;
    assign bus.req = (state == cpu_pkg::ex_mem_req);
    assign bus.we = cur.is_store;
    assign bus.addr = mem_addr[cpu_pkg::addr_bits+1:2];
    assign bus.wdata = cur.rs2_value;

    assign done = (state == cpu_pkg::ex_idle && dec.valid && !mem_op)
                || (state == cpu_pkg::ex_mem_req && bus.gnt && cur.is_store)
                || (state == cpu_pkg::ex_mem_data);

    assign rf_we = done && (cur.rd != 5'd0);
    assign rf_waddr = rf_we ? cur.rd : 5'd0;
    assign rf_wdata = cur.is_load ? bus.rdata : alu_result;

    assign branch_taken = cur.is_branch && ((cur.rs1_value == cur.rs2_value) != cur.branch_ne);
    assign branch_target = cur.pc + cur.imm;
    assign halt = cur.is_halt;
    assign retire_pc = cur.pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::ex_idle;
        end else begin
            case (state)
                cpu_pkg::ex_idle: begin
                    if (dec.valid && mem_op) begin
                        held <= dec;
                        state <= cpu_pkg::ex_mem_req;
                    end
                end
                cpu_pkg::ex_mem_req: begin
                    if (bus.gnt) begin
                        state <= held.is_load ? cpu_pkg::ex_mem_data : cpu_pkg::ex_idle;
                    end
                end
                default: state <= cpu_pkg::ex_idle;
            endcase
        end
    end

endmodule

//--- fetch.sv
module fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic                     halted,
    mem_bus_if.master                bus,
    output logic                     instr_valid,
    output logic [31:0]              instr,
    output logic [cpu_pkg::xlen-1:0] instr_pc,
    input  logic                     done,
    input  logic                     branch_taken,
    input  logic [cpu_pkg::xlen-1:0] branch_target,
    input  logic                     halt
);

    logic [2:0]               state;
    logic [cpu_pkg::xlen-1:0] pc;

    assign bus.req = (state == cpu_pkg::fetch_request);
    assign bus.we = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr = pc[cpu_pkg::addr_bits+1:2];  // Byte pc to word address

    assign instr_valid = (state == cpu_pkg::fetch_wait_data);
    assign instr = bus.rdata;
    assign instr_pc = pc;
    assign halted = (state == cpu_pkg::fetch_halted);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::fetch_idle;
            pc <= '0;
        end else begin
            case (state)
                cpu_pkg::fetch_idle: begin
                    if (start) begin
                        state <= cpu_pkg::fetch_request;
                    end
                end
                cpu_pkg::fetch_request: begin
                    if (bus.gnt) begin
                        state <= cpu_pkg::fetch_wait_data;
                    end
                end
                cpu_pkg::fetch_wait_data: state <= cpu_pkg::fetch_wait_done;
                cpu_pkg::fetch_wait_done: begin
                    if (done && halt) begin
                        state <= cpu_pkg::fetch_halted;
                    end else if (done) begin
                        pc <= branch_taken ? branch_target : pc + 32'd4;
                        state <= cpu_pkg::fetch_request;
                    end
                end
                cpu_pkg::fetch_halted: state <= cpu_pkg::fetch_halted;  // Only reset leaves
                default: state <= cpu_pkg::fetch_idle;
            endcase
        end
    end

endmodule

//--- mem_arbiter.sv
module mem_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    mem_bus_if.slave                      ld,
    mem_bus_if.slave                      dm,
    mem_bus_if.slave                      im,
    output logic                          ram_en,
    output logic                          ram_we,
    output logic [cpu_pkg::addr_bits-1:0] ram_addr,
    output logic [cpu_pkg::xlen-1:0]      ram_wdata,
    input  logic [cpu_pkg::xlen-1:0]      ram_rdata
);

    logic       g_ld;
    logic       g_dm;
    logic       g_im;
    logic [2:0] owner;  // Who gets the data returned this cycle

    assign g_ld = ld.req;
    assign g_dm = dm.req && !ld.req;
    assign g_im = im.req && !ld.req && !dm.req;

    assign ld.gnt = g_ld;
    assign dm.gnt = g_dm;
    assign im.gnt = g_im;
    assign ram_en = g_ld || g_dm || g_im;

    always_comb begin
        if (g_ld) begin
            ram_we = ld.we;
            ram_addr = ld.addr;
            ram_wdata = ld.wdata;
        end else if (g_dm) begin
            ram_we = dm.we;
            ram_addr = dm.addr;
            ram_wdata = dm.wdata;
        end else begin
            ram_we = im.we && g_im;
            ram_addr = im.addr;
            ram_wdata = im.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= 3'b000;
        end else begin
            owner <= {g_ld, g_dm, g_im};
        end
    end

    assign ld.rdata = owner[2] ? ram_rdata : '0;
    assign dm.rdata = owner[1] ? ram_rdata : '0;
    assign im.rdata = owner[0] ? ram_rdata : '0;

endmodule

//--- mem_bus_if.sv
interface mem_bus_if;

    logic                         req;
    logic                         we;
    logic [cpu_pkg::addr_bits-1:0] addr;
    logic [cpu_pkg::xlen-1:0]      wdata;
    logic [cpu_pkg::xlen-1:0]      rdata;  // Valid the cycle after gnt
    logic                         gnt;

    modport master (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

//--- register_bank.sv
module register_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [4:0]               waddr,
    input  logic [cpu_pkg::xlen-1:0] wdata,
    input  logic [4:0]               raddr1,
    input  logic [4:0]               raddr2,
    output logic [cpu_pkg::xlen-1:0] rdata1,
    output logic [cpu_pkg::xlen-1:0] rdata2
);

    logic [cpu_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cpu.f --top-module tb_cpu -o tb_cpu
./obj_dir/tb_cpu

//--- tb_cpu.sv
module tb_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] opc_reg = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [31:0] ecall_word = 32'h00000073;
    localparam int data_base = 288;  // Preloaded data words sit above the store area
    localparam int data_words = 32;

    logic        clk;
    logic        rst;
    logic        start;
    logic        load_en;
    logic [9:0]  load_addr;
    logic [31:0] load_data;
    logic        load_busy;
    logic        halted;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    logic [31:0] prog [64];
    logic [31:0] model_mem [1024];
    logic [31:0] exp_pc_q [64];
    logic [4:0]  exp_rd_q [64];
    logic [31:0] exp_value_q [64];
    int          n_prog;
    int          n_retire;
    int          ret_count;
    logic [5:0]  ret_idx;
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_value;
    logic        started;
    logic        finished;
    logic        prog_ready;
    logic        halted_q;

    cpu DUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .load_busy(load_busy),
        .halted(halted),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc),
        .retire_rd(retire_rd),
        .retire_value(retire_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        abort_run();
    endtask

    task automatic protocol_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opc_lui};
    endfunction

    function automatic logic [31:0] fill_word(input logic [9:0] a);
        return {a, ~a, a, 2'b01};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[n_prog[5:0]] = w;
        n_prog++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] off_a;
        logic [11:0] off_b;
        n_prog = 0;
        r = $urandom();
        emit(u_type(r[19:0], 5'd1));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd1, 3'b000, 5'd1));
        r = $urandom();
        emit(u_type(r[19:0], 5'd2));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd2, 3'b000, 5'd2));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd0, 3'b000, 5'd3));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
        emit(r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd6));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd0, 3'b000, 5'd0));  // Both x0 writes vanish
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd9));
        emit(i_type(opc_imm, 12'd1024, 5'd0, 3'b000, 5'd10));
        r = $urandom();
        off_a = {5'd0, r[4:0], 2'b00};
        off_b = {4'd0, 1'b1, r[9:5], 2'b00};
        emit(s_type(off_a, 5'd4, 5'd10));
        emit(i_type(opc_load, off_a, 5'd10, 3'b010, 5'd11));
        emit(i_type(opc_load, off_b, 5'd10, 3'b010, 5'd12));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd1, 3'b111, 5'd13));
        emit(i_type(opc_imm, r[23:12], 5'd2, 3'b110, 5'd14));
        r = $urandom();
        emit(i_type(opc_imm, r[11:0], 5'd3, 3'b100, 5'd15));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));  // Taken so the next word is skipped
        emit(i_type(opc_imm, 12'd1, 5'd0, 3'b000, 5'd20));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));
        emit(i_type(opc_imm, 12'd2, 5'd0, 3'b000, 5'd16));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
        emit(i_type(opc_imm, 12'd3, 5'd0, 3'b000, 5'd21));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));
        emit(r_type(7'h00, 5'd12, 5'd11, 3'b000, 5'd17));
        emit(ecall_word);
    endtask

    // ISA-level model of the program that records one retire per instruction
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] iw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  wr_rd;
        logic        stop;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            model_mem[i[9:0]] = '0;
        end
        for (int i = 0; i < n_prog; i++) begin
            model_mem[i[9:0]] = prog[i[5:0]];
        end
        for (int i = data_base; i < data_base + data_words; i++) begin
            model_mem[i[9:0]] = fill_word(i[9:0]);
        end
        pc = '0;
        stop = 1'b0;
        steps = 0;
        n_retire = 0;
        while (!stop && steps < 64) begin
            iw = model_mem[pc[11:2]];
            a = regs[iw[19:15]];
            b = regs[iw[24:20]];
            imm_i = {{20{iw[31]}}, iw[31:20]};
            next_pc = pc + 32'd4;
            wr_rd = 5'd0;
            res = '0;
            case (iw[6:0])
                opc_reg, opc_imm: begin
                    if (iw[6:0] == opc_imm) begin
                        b = imm_i;
                    end
                    wr_rd = iw[11:7];
                    case (iw[14:12])
                        3'b000: res = (iw[6:0] == opc_reg && iw[30]) ? a - b : a + b;
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        3'b111: res = a & b;
                        default: wr_rd = 5'd0;
                    endcase
                end
                opc_load: begin
                    addr = a + imm_i;
                    res = model_mem[addr[11:2]];
                    wr_rd = iw[11:7];
                end
                opc_store: begin
                    addr = a + {{20{iw[31]}}, iw[31:25], iw[11:7]};
                    model_mem[addr[11:2]] = b;
                end
                opc_branch: begin
                    if (iw[14:13] == 2'b00 && ((a == b) != iw[12])) begin
                        next_pc = pc + {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
                    end
                end
                opc_lui: begin
                    res = {iw[31:12], 12'd0};
                    wr_rd = iw[11:7];
                end
                default: stop = (iw == ecall_word);
            endcase
            exp_pc_q[n_retire[5:0]] = pc;
            exp_rd_q[n_retire[5:0]] = wr_rd;
            exp_value_q[n_retire[5:0]] = res;
            n_retire++;
            if (wr_rd != 5'd0) begin
                regs[wr_rd] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic load_word(input logic [9:0] a, input logic [31:0] d);
        @(negedge clk);
        load_en = 1'b1;
        load_addr = a;
        load_data = d;
        @(posedge clk);
        while (load_busy) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ret_count <= 0;
            halted_q <= 1'b0;
        end else begin
            halted_q <= halted;
            if (retire_valid) begin
                ret_count <= ret_count + 1;
            end
        end
    end

    assign ret_idx = ret_count[5:0];
    assign exp_pc = exp_pc_q[ret_idx];  // Next retire the model expects
    assign exp_rd = exp_rd_q[ret_idx];
    assign exp_value = exp_value_q[ret_idx];

    a_retire_pc: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_pc == exp_pc)
        else value_mismatch("retire_pc", $sampled(exp_pc), $sampled(retire_pc));

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rd == exp_rd)
        else value_mismatch("retire_rd", {27'd0, $sampled(exp_rd)}, {27'd0, $sampled(retire_rd)});

    a_retire_value: assert property (@(posedge clk) disable iff (rst)
        (retire_valid && exp_rd != 5'd0) |-> retire_value == exp_value)
        else value_mismatch("retire_value", $sampled(exp_value), $sampled(retire_value));

    a_extra_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> ret_count < n_retire)
        else protocol_error("More instructions retired than the program executes");

    // The load port has top priority, so it is granted in every cycle it requests
    a_load_busy: assert property (@(posedge clk) disable iff (rst)
        load_busy == !load_en)
        else value_mismatch("load_busy", {31'd0, !$sampled(load_en)},
                            {31'd0, $sampled(load_busy)});

    a_idle_retire: assert property (@(posedge clk) disable iff (rst)
        !started |-> !retire_valid)
        else protocol_error("retire_valid pulsed before start");

    a_idle_halted: assert property (@(posedge clk) disable iff (rst)
        !started |-> !halted)
        else protocol_error("halted went high before start");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halted_q |-> halted)
        else protocol_error("halted dropped after the core had halted");

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halted |-> !retire_valid)
        else protocol_error("An instruction retired after the core halted");

    a_end_count: assert property (@(posedge clk) disable iff (rst)
        finished |-> ret_count == n_retire)
        else value_mismatch("retire count", $sampled(n_retire), $sampled(ret_count));

    initial begin : watchdog
        int limit;
        wait (prog_ready);
        limit = n_prog * 200 + 2 * (n_prog + data_words) + 100;
        repeat (limit) @(posedge clk);
        protocol_error("Timeout, the core did not halt in time");
    end

    initial begin
        void'($urandom(3312));
        rst = 1'b1;
        start = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        started = 1'b0;
        finished = 1'b0;
        prog_ready = 1'b0;
        build_program();
        run_model();
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_prog; i++) begin
            load_word(i[9:0], prog[i[5:0]]);
        end
        for (int i = data_base; i < data_base + data_words; i++) begin
            load_word(i[9:0], fill_word(i[9:0]));
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (3) @(negedge clk);
        start = 1'b1;
        started = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        repeat (50) @(negedge clk);  // The core must stay quiet here
        finished = 1'b1;
        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- unified_ram.sv
module unified_ram (
    input  logic                          clk,
    input  logic                          en,
    input  logic                          we,
    input  logic [cpu_pkg::addr_bits-1:0] addr,
    input  logic [cpu_pkg::xlen-1:0]      wdata,
    output logic [cpu_pkg::xlen-1:0]      rdata
);

    logic [cpu_pkg::xlen-1:0] mem [cpu_pkg::mem_words];

    // A write returns the old word on rdata
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule
